/* logic/rx_ffe_pkg.sv */
package rx_ffe_pkg;

    // sample and coefficient widths
    localparam int code_width   = 8;
    localparam int weight_width = 8;
    localparam int shift_width  = 4;
    localparam int result_width = 10;

    // upper bounds for the module parameters
    localparam int max_depth    = 16;
    localparam int max_channels = 4;

    // one spare bit so that indices past the bounds can still be encoded
    localparam int idx_width = $clog2(max_depth) + 1;

    typedef logic signed [code_width-1:0]   code_t;
    typedef logic signed [weight_width-1:0] weight_t;
    typedef logic        [shift_width-1:0]  shift_t;
    typedef logic signed [result_width-1:0] result_t;
    typedef logic        [idx_width-1:0]    idx_t;

    // adc codes of one clock with code[0] as the oldest sample
    typedef struct packed {
        code_t [max_channels-1:0] code;
    } code_word_t;

    // equalized results and sliced bits per channel
    typedef struct packed {
        result_t [max_channels-1:0] result;
        logic    [max_channels-1:0] decision;
    } ffe_out_t;

    typedef enum logic {
        cfg_weight = 1'b0,
        cfg_shift  = 1'b1
    } cfg_kind_e;

    // kind is the msb in both views of the config word
    typedef struct packed {
        cfg_kind_e kind;
        idx_t      tap_idx;
        idx_t      chan_idx;
        weight_t   value;
    } weight_cmd_t;

    typedef struct packed {
        cfg_kind_e                                     kind;
        idx_t                                          chan_idx;
        logic [idx_width+weight_width-shift_width-1:0] pad;
        shift_t                                        amount;
    } shift_cmd_t;

    // 19 bit config word
    typedef union packed {
        weight_cmd_t weight;
        shift_cmd_t  shift;
    } cfg_word_t;

endpackage

/* logic/ffe_config_regs.sv */
module ffe_config_regs #(
    parameter int ffe_depth    = 4,
    parameter int num_channels = 2
) (
    input  logic                                                  clk,
    input  logic                                                  arst_n_i,
    input  logic                                                  cfg_we_i,
    input  rx_ffe_pkg::cfg_word_t                                 cfg_word_i,
    output rx_ffe_pkg::weight_t [ffe_depth-1:0][num_channels-1:0] weights_o,
    output rx_ffe_pkg::shift_t  [num_channels-1:0]                shifts_o
);
    import rx_ffe_pkg::*;

    cfg_kind_e kind;
    idx_t      tap_sel;
    idx_t      wchan_sel;
    idx_t      schan_sel;
    logic      tap_ok;
    logic      wchan_ok;
    logic      schan_ok;
    logic      weight_wr;
    logic      shift_wr;

    // same bit position in both members
    assign kind = cfg_word_i.weight.kind;

    // weight view
    assign tap_sel   = cfg_word_i.weight.tap_idx;
    assign wchan_sel = cfg_word_i.weight.chan_idx;

    // shift view
    assign schan_sel = cfg_word_i.shift.chan_idx;

    // drop writes that point past the configured table
    assign tap_ok   = tap_sel < idx_t'(ffe_depth);
    assign wchan_ok = wchan_sel < idx_t'(num_channels);
    assign schan_ok = schan_sel < idx_t'(num_channels);

    assign weight_wr = cfg_we_i && (kind == cfg_weight) && tap_ok && wchan_ok;
    assign shift_wr  = cfg_we_i && (kind == cfg_shift) && schan_ok;

    // weight table
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            weights_o <= '0;
        end else if (weight_wr) begin
            weights_o[tap_sel][wchan_sel] <= cfg_word_i.weight.value;
        end
    end

    // per-channel right shift
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            shifts_o <= '0;
        end else if (shift_wr) begin
            shifts_o[schan_sel] <= cfg_word_i.shift.amount;
        end
    end

endmodule

/* logic/flat_ffe.sv */
module flat_ffe #(
    parameter int ffe_depth    = 4,
    parameter int num_channels = 2
) (
    input  logic                                                  clk,
    input  logic                                                  arst_n_i,
    input  logic                                                  code_valid_i,
    input  rx_ffe_pkg::code_word_t                                codes_i,
    input  rx_ffe_pkg::weight_t [ffe_depth-1:0][num_channels-1:0] weights_i,
    input  rx_ffe_pkg::shift_t  [num_channels-1:0]                shifts_i,
    output logic                                                  res_valid_o,
    output rx_ffe_pkg::ffe_out_t                                  res_o
);
    import rx_ffe_pkg::*;

    // history keeps the last ffe_depth-1 samples of the flat stream
    localparam int hist_len   = (ffe_depth > 1) ? ffe_depth - 1 : 1;
    localparam int stream_len = hist_len + num_channels;
    localparam int prod_width = code_width + weight_width;
    // headroom for the adder tree
    localparam int sum_width  = prod_width + $clog2(ffe_depth) + 1;

    localparam logic signed [sum_width-1:0] res_max = (2 ** (result_width - 1)) - 1;
    localparam logic signed [sum_width-1:0] res_min = -(2 ** (result_width - 1));

    typedef logic signed [prod_width-1:0] prod_t;
    typedef logic signed [sum_width-1:0]  sum_t;

    code_t   [hist_len-1:0]     history_q;
    code_t   [stream_len-1:0]   stream;
    prod_t                      prod_q [ffe_depth][num_channels];
    result_t [num_channels-1:0] sat_res;
    logic    [num_channels-1:0] dec_res;
    logic    [1:0]              valid_q;
    ffe_out_t                   res_q;

    // history in the low entries, newest word on top
    assign stream = {codes_i.code[num_channels-1:0], history_q};

    // history only moves on valid words
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            history_q <= '0;
        end else if (code_valid_i) begin
            history_q <= stream[stream_len-1 -: hist_len];
        end
    end

    // stage 1
    // tap i of channel j looks i samples back in the stream
    always_ff @(posedge clk) begin
        if (code_valid_i) begin
            for (int i = 0; i < ffe_depth; i++) begin
                for (int j = 0; j < num_channels; j++) begin
                    prod_q[i][j] <= $signed(stream[hist_len + j - i])
                                  * $signed(weights_i[i][j]);
                end
            end
        end
    end

    // stage 2 datapath
    always_comb begin
        sum_t    acc;
        sum_t    shifted;
        result_t sat;

        for (int j = 0; j < num_channels; j++) begin
            acc = '0;
            for (int i = 0; i < ffe_depth; i++) begin
                acc = acc + sum_t'(prod_q[i][j]);
            end

            // arithmetic shift keeps the sign
            shifted = acc >>> shifts_i[j];

            // clip to the result range
            if (shifted > res_max) begin
                sat = res_max[result_width-1:0];
            end else if (shifted < res_min) begin
                sat = res_min[result_width-1:0];
            end else begin
                sat = shifted[result_width-1:0];
            end

            sat_res[j] = sat;
            // zero slices to 0
            dec_res[j] = (sat > 0);
        end
    end

    // stage 2 register
    // unused channels stay at their reset value
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            res_q <= '0;
        end else if (valid_q[0]) begin
            res_q.result[num_channels-1:0]   <= sat_res;
            res_q.decision[num_channels-1:0] <= dec_res;
        end
    end

    // valid travels with the two data stages
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= code_valid_i;
            valid_q[1] <= valid_q[0];
        end
    end

    assign res_valid_o = valid_q[1];
    assign res_o       = res_q;

endmodule

/* logic/rx_ffe_top.sv */
module rx_ffe_top #(
    parameter int ffe_depth    = 4,
    parameter int num_channels = 2
) (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  logic                   cfg_we_i,
    input  rx_ffe_pkg::cfg_word_t  cfg_word_i,
    input  logic                   code_valid_i,
    input  rx_ffe_pkg::code_word_t codes_i,
    output logic                   res_valid_o,
    output rx_ffe_pkg::ffe_out_t   res_o
);
    import rx_ffe_pkg::*;

    // config levels into the equalizer
    weight_t [ffe_depth-1:0][num_channels-1:0] weights;
    shift_t  [num_channels-1:0]                shifts;

    // weight table and shifts
    ffe_config_regs #(
        .ffe_depth    (ffe_depth),
        .num_channels (num_channels)
    ) i_ffe_config_regs (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .cfg_we_i   (cfg_we_i),
        .cfg_word_i (cfg_word_i),
        .weights_o  (weights),
        .shifts_o   (shifts)
    );

    // equalizer and slicer
    flat_ffe #(
        .ffe_depth    (ffe_depth),
        .num_channels (num_channels)
    ) i_flat_ffe (
        .clk          (clk),
        .arst_n_i     (arst_n_i),
        .code_valid_i (code_valid_i),
        .codes_i      (codes_i),
        .weights_i    (weights),
        .shifts_i     (shifts),
        .res_valid_o  (res_valid_o),
        .res_o        (res_o)
    );

endmodule

/* dv/rx_ffe_assert.sv */
module rx_ffe_assert (
    input logic                 clk,
    input logic                 arst_n_i,
    input logic                 cfg_we_i,
    input logic                 code_valid_i,
    input logic                 res_valid_i,
    input rx_ffe_pkg::ffe_out_t res_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic cfg_seen;
    int   fail_count = 0;

    // any write counts, even one that is dropped
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cfg_seen <= 1'b0;
        end else if (cfg_we_i) begin
            cfg_seen <= 1'b1;
        end
    end

    reset_quiet: assert property (@(posedge clk) !arst_n_i |-> !res_valid_i)
        else begin
            fail_count++;
            $error("res_valid_o high while reset is asserted");
        end

    // two register stages from word to result
    valid_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
                                    res_valid_i == $past(code_valid_i, 2))
        else begin
            fail_count++;
            $error("res_valid_o does not follow code_valid_i by two cycles");
        end

    zero_before_cfg: assert property (@(posedge clk) disable iff (!arst_n_i)
                                      !cfg_seen |-> (res_i == '0))
        else begin
            fail_count++;
            $error("res_o nonzero before any configuration write");
        end

endmodule

bind rx_ffe_top rx_ffe_assert i_rx_ffe_assert (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .cfg_we_i     (cfg_we_i),
    .code_valid_i (code_valid_i),
    .res_valid_i  (res_valid_o),
    .res_i        (res_o)
);

/* dv/rx_ffe_tb.sv */
module rx_ffe_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import rx_ffe_pkg::*;

    localparam int ffe_depth    = 4;
    localparam int num_channels = 2;
    localparam int rec_fields   = 5;
    localparam int max_records  = 256;

    // record tags in the pattern file
    localparam logic [15:0] tag_cfg    = 16'h1;
    localparam logic [15:0] tag_word   = 16'h2;
    localparam logic [15:0] tag_gapped = 16'h3;
    localparam logic [15:0] tag_expect = 16'h4;

    logic       clk;
    logic       arst_n;
    logic       cfg_we;
    cfg_word_t  cfg_word;
    logic       code_valid;
    code_word_t codes;
    logic       res_valid;
    ffe_out_t   res;

    logic [15:0] pat_mem [0:rec_fields*max_records-1];
    ffe_out_t    expect_q [$];
    int          num_records;
    int          num_driven  = 0;
    int          num_checked = 0;
    int          cycle_count = 0;
    int          cycle_limit = 100;
    int          seed;

    rx_ffe_top #(
        .ffe_depth    (ffe_depth),
        .num_channels (num_channels)
    ) i_rx_ffe_top (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .cfg_we_i     (cfg_we),
        .cfg_word_i   (cfg_word),
        .code_valid_i (code_valid),
        .codes_i      (codes),
        .res_valid_o  (res_valid),
        .res_o        (res)
    );

    always #5 clk = ~clk;

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic compare(input integer actual, input integer expected, input string what);
        if (actual !== expected) begin
            stop_with_failure($sformatf("** Error at %0t: %s is %0d, expected %0d",
                                        $time, what, actual, expected));
        end
    endtask

    // kind 1 selects the shift view of the union
    function automatic cfg_word_t make_cfg(input logic [15:0] kind, input logic [15:0] a,
                                           input logic [15:0] b, input logic [15:0] value);
        cfg_word_t w;
        w = '0;
        if (kind[0]) begin
            w.shift.kind     = cfg_shift;
            w.shift.chan_idx = idx_t'(a);
            w.shift.amount   = shift_t'(value);
        end else begin
            w.weight.kind     = cfg_weight;
            w.weight.tap_idx  = idx_t'(a);
            w.weight.chan_idx = idx_t'(b);
            w.weight.value    = weight_t'(value);
        end
        return w;
    endfunction

    function automatic code_word_t word_from(input int base);
        code_word_t w;
        w         = '0;
        w.code[0] = code_t'(pat_mem[base+1]);
        w.code[1] = code_t'(pat_mem[base+2]);
        return w;
    endfunction

    // unused channels are expected at zero
    function automatic ffe_out_t expected_from(input int base);
        ffe_out_t w;
        w             = '0;
        w.result[0]   = result_t'(pat_mem[base+1]);
        w.result[1]   = result_t'(pat_mem[base+2]);
        w.decision[0] = pat_mem[base+3][0];
        w.decision[1] = pat_mem[base+4][0];
        return w;
    endfunction

    task automatic load_patterns();
        logic [15:0] tag;
        for (int k = 0; k < rec_fields * max_records; k++) begin
            pat_mem[k] = '1;
        end
        $readmemh("dv/rx_ffe_patterns.mem", pat_mem);
        num_records = 0;
        for (int r = 0; r < max_records; r++) begin
            tag = pat_mem[r * rec_fields];
            if (tag < tag_cfg || tag > tag_expect) begin
                break;
            end
            num_records++;
            if (tag == tag_expect) begin
                expect_q.push_back(expected_from(r * rec_fields));
            end
        end
        if (num_records == 0 || expect_q.size() == 0) begin
            stop_with_failure("no usable records found in dv/rx_ffe_patterns.mem");
        end
        cycle_limit = 4 * num_records + 100;
    endtask

    task automatic wait_idle();
        while (num_checked < num_driven) begin
            @(negedge clk);
        end
    endtask

    task automatic write_config(input int base);
        cfg_we   = 1'b1;
        cfg_word = make_cfg(pat_mem[base+1], pat_mem[base+2], pat_mem[base+3], pat_mem[base+4]);
        @(negedge clk);
        cfg_we   = 1'b0;
        cfg_word = '0;
    endtask

    task automatic drive_word(input int base, input int gap);
        repeat (gap) @(negedge clk);
        code_valid = 1'b1;
        codes      = word_from(base);
        num_driven++;
        @(negedge clk);
        code_valid = 1'b0;
        codes      = '0;
    endtask

    // outputs settle after the rising edge
    always @(negedge clk) begin
        ffe_out_t want;
        if (arst_n === 1'b1 && res_valid === 1'b1) begin
            if (expect_q.size() == 0) begin
                stop_with_failure("a result came out with no expected record left");
            end else begin
                want = expect_q.pop_front();
                for (int j = 0; j < max_channels; j++) begin
                    compare(integer'(res.result[j]), integer'(want.result[j]),
                            $sformatf("word %0d channel %0d result", num_checked, j));
                    compare(integer'(res.decision[j]), integer'(want.decision[j]),
                            $sformatf("word %0d channel %0d decision", num_checked, j));
                end
                num_checked++;
            end
        end
    end

    // a failed timing assertion ends the run at once
    always @(negedge clk) begin
        if (i_rx_ffe_top.i_rx_ffe_assert.fail_count != 0) begin
            stop_with_failure($sformatf("%0d assertion failures on the DUT timing",
                                        i_rx_ffe_top.i_rx_ffe_assert.fail_count));
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles with %0d of %0d words checked",
                                        cycle_limit, num_checked, num_driven));
        end
    end

    initial begin
        logic [15:0] tag;
        int          gap;
        clk        = 1'b0;
        arst_n     = 1'b0;
        cfg_we     = 1'b0;
        cfg_word   = '0;
        code_valid = 1'b0;
        codes      = '0;
        seed       = 88;
        load_patterns();

        repeat (5) @(negedge clk);
        arst_n = 1'b1;

        for (int r = 0; r < num_records; r++) begin
            tag = pat_mem[r * rec_fields];
            if (tag == tag_cfg) begin
                // words in flight finish with the old settings
                wait_idle();
                write_config(r * rec_fields);
            end else if (tag == tag_word || tag == tag_gapped) begin
                gap = (tag == tag_gapped) ? int'($unsigned($random(seed)) % 3) : 0;
                drive_word(r * rec_fields, gap);
            end
        end

        wait_idle();
        // catch stray results
        repeat (4) @(negedge clk);

        if (num_checked != num_driven || expect_q.size() != 0 ||
            i_rx_ffe_top.i_rx_ffe_assert.fail_count != 0) begin
            stop_with_failure($sformatf("%0d words driven, %0d checked, %0d expected left, %0d %s",
                                        num_driven, num_checked, expect_q.size(),
                                        i_rx_ffe_top.i_rx_ffe_assert.fail_count,
                                        "assertion failures"));
        end else begin
            $display("All checks passed");
            $finish;
        end
    end

endmodule

/* dv/rx_ffe_patterns.mem */
// tag 1 config: kind (0 weight, 1 shift), tap or channel, channel, weight or shift amount
// tag 2 word back to back, tag 3 word after a random gap: code0 code1 0 0
// tag 4 expected output in order: result0 result1 decision0 decision1
// nothing configured, all outputs zero
2 05 fd 0 0
2 7f 80 0 0
4 000 000 0 0
4 000 000 0 0
// single tap of weight 1 passes codes through
1 0 0 0 01
1 0 0 1 01
3 0a f9 0 0
3 00 64 0 0
3 ff 00 0 0
4 00a 3f9 1 0
4 000 064 0 1
4 3ff 000 0 0
// multi tap, shift 1 on channel 0 and 2 on channel 1
1 0 0 0 03
1 0 1 0 fe
1 0 2 0 01
1 0 1 1 01
1 0 2 1 01
1 0 3 1 01
1 1 0 0 1
1 1 1 0 2
2 14 08 0 0
2 f4 28 0 0
2 06 e2 0 0
4 01d 006 1 1
4 3f0 00e 0 1
4 3db 001 0 1
// saturation at both ends
1 0 0 0 7f
1 0 1 0 00
1 0 2 0 00
1 0 0 1 80
1 0 1 1 00
1 0 2 1 00
1 0 3 1 00
1 1 0 0 0
1 1 1 0 0
3 7f 7f 0 0
3 80 80 0 0
3 02 fd 0 0
4 1ff 200 1 0
4 200 1ff 0 1
4 0fe 180 1 1
// same words back to back and then with gaps
1 0 0 0 01
1 0 1 0 02
1 0 3 0 ff
1 0 0 1 02
1 0 2 1 ff
1 0 3 1 01
1 1 1 0 1
2 00 00 0 0
2 00 00 0 0
2 04 fe 0 0
2 08 03 0 0
2 fb f7 0 0
4 07a 002 1 1
4 003 000 1 0
4 004 3fe 1 0
4 004 006 1 1
4 003 3f9 1 0
3 00 00 0 0
3 00 00 0 0
3 04 fe 0 0
3 08 03 0 0
3 fb f7 0 0
4 3eb 002 0 1
4 009 000 1 0
4 004 3fe 1 0
4 004 006 1 1
4 003 3f9 1 0
// out of range writes change nothing
1 0 4 0 37
1 0 0 2 37
1 1 3 0 5
1 0 a 1 37
3 00 00 0 0
3 00 00 0 0
3 04 fe 0 0
3 08 03 0 0
4 3eb 002 0 1
4 009 000 1 0
4 004 3fe 1 0
4 004 006 1 1

/* rx_ffe.f */
logic/rx_ffe_pkg.sv
logic/ffe_config_regs.sv
logic/flat_ffe.sv
logic/rx_ffe_top.sv
dv/rx_ffe_assert.sv
dv/rx_ffe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the rx_ffe testbench with verilator

cd "$(dirname "$0")" || exit 1

build_dir=build
log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module rx_ffe_tb -Mdir "$build_dir" -f rx_ffe.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$build_dir/Vrx_ffe_tb" > "$log" 2>&1
status=$?
cat "$log"

if grep -q "Checks failed" "$log"; then
    echo "simulation failed"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi
echo "simulation passed"
exit 0
